// ==== src/pixel_window_cfg.svh ====
// PW_WIDTH must be at least 4 and PW_HEIGHT at least 3 while PW_BANKS stays at 5
`ifndef PIXEL_WINDOW_CFG_SVH
`define PIXEL_WINDOW_CFG_SVH

// pixels per source row
`define PW_WIDTH 8

// rows per frame
`define PW_HEIGHT 6

// bits per pixel, packed rgb
`define PW_PIXEL_BITS 24

// four rows in the window plus one row being filled
`define PW_BANKS 5

`endif

// ==== src/pixel_pkg.sv ====
// widths follow pixel_window_cfg.svh and row_t leaves headroom up to PW_HEIGHT+3
`include "pixel_window_cfg.svh"

package pixel_pkg;

    // one pixel as it arrives on in_pixel
    typedef logic [`PW_PIXEL_BITS-1:0] pixel_t;

    // column index, must also reach PW_WIDTH as the end marker
    typedef logic [$clog2(`PW_WIDTH+1)-1:0] col_t;

    // row index with room for the look-ahead of three rows past the frame
    typedef logic [$clog2(`PW_HEIGHT+4)-1:0] row_t;

endpackage

// ==== src/ctrl_pkg.sv ====
// bank_t covers exactly five banks and the sequencer uses only three state codes
package ctrl_pkg;

    // bank number 0 to 4
    typedef logic [2:0] bank_t;

    // FILL waits for rows, RUN emits one output row, DONE ends the frame
    typedef enum logic [1:0] {
        FILL = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } seq_state_e;

endpackage

// ==== src/bank_if.sv ====
// rd_bank entries are already clamped to the frame and stay constant during an output row
interface bank_if;

    // write side, one pixel per accepted input
    logic                    wr_en;
    ctrl_pkg::bank_t         wr_bank;
    pixel_pkg::col_t         wr_col;

    // bank feeding each window row, index 0 is the top row
    ctrl_pkg::bank_t [3:0]   rd_bank;

    modport seq (
        output wr_en,
        output wr_bank,
        output wr_col,
        output rd_bank
    );

    modport store (
        input  wr_en,
        input  wr_bank,
        input  wr_col,
        input  rd_bank
    );

endinterface

// ==== src/row_sequencer.sv ====
// handles a single frame per reset and then holds frame_done until rst_n is asserted
`include "pixel_window_cfg.svh"

module row_sequencer import pixel_pkg::*, ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  logic  row_done,
    output logic  row_active,
    output logic  frame_done,
    bank_if.seq   bank
);

    localparam row_t  LAST_ROW  = row_t'(`PW_HEIGHT - 1);
    localparam col_t  LAST_COL  = col_t'(`PW_WIDTH - 1);
    localparam bank_t LAST_BANK = bank_t'(`PW_BANKS - 1);

    seq_state_e state;
    row_t       wr_row;
    col_t       wr_col;
    bank_t      wr_bank_q;
    row_t       out_row;
    bank_t      top_bank;
    row_t       need_row;
    row_t       top_row;
    row_t       span;
    logic       in_hs;
    logic       row_end;

    // source row k lives in bank k mod 5
    function automatic bank_t bank_add(bank_t base, logic [1:0] off);
        logic [3:0] sum;
        sum = {1'b0, base} + {2'b00, off};
        if (sum >= 4'(`PW_BANKS)) begin
            sum = sum - 4'(`PW_BANKS);
        end
        return sum[2:0];
    endfunction

    // row k may be written only once row k-5 has left the window
    assign in_ready = (wr_row < row_t'(`PW_HEIGHT)) && (wr_row <= out_row + row_t'(3));
    assign in_hs    = in_valid && in_ready;
    assign row_end  = in_hs && (wr_col == LAST_COL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_row    <= '0;
            wr_col    <= '0;
            wr_bank_q <= '0;
        end else if (in_hs) begin
            wr_col <= row_end ? '0 : wr_col + col_t'(1);
            if (row_end) begin
                wr_row    <= wr_row + row_t'(1);
                wr_bank_q <= (wr_bank_q == LAST_BANK) ? '0 : wr_bank_q + bank_t'(1);
            end
        end
    end

    // lowest source row the output row r still needs, clamped at the bottom
    assign need_row = (out_row + row_t'(2) > LAST_ROW) ? LAST_ROW : out_row + row_t'(2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FILL;
            out_row  <= '0;
            top_bank <= '0;
        end else begin
            case (state)
                FILL: begin
                    if (wr_row > need_row) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (row_done) begin
                        if (out_row == LAST_ROW) begin
                            state <= DONE;
                        end else begin
                            state   <= FILL;
                            out_row <= out_row + row_t'(1);
                            // top row stays at 0 when moving from row 0 to row 1
                            if (out_row != '0) begin
                                top_bank <= bank_add(top_bank, 2'd1);
                            end
                        end
                    end
                end
                default: state <= state;
            endcase
        end
    end

    assign row_active = (state == RUN);
    assign frame_done = (state == DONE);

    assign top_row = (out_row == '0) ? '0 : out_row - row_t'(1);
    assign span    = LAST_ROW - top_row;

    // window rows r-1..r+2 as offsets from the clamped top row
    always_comb begin
        logic [1:0] off;
        for (int j = 0; j < 4; j++) begin
            off = (out_row == '0 && j > 0) ? 2'(j - 1) : 2'(j);
            if (row_t'(off) > span) begin
                off = span[1:0];
            end
            bank.rd_bank[j] = bank_add(top_bank, off);
        end
    end

    assign bank.wr_en   = in_hs;
    assign bank.wr_bank = wr_bank_q;
    assign bank.wr_col  = wr_col;

    a_write_avoids_window: assert property (@(posedge clk) disable iff (!rst_n)
        (row_active && bank.wr_en) |->
            (bank.wr_bank != bank.rd_bank[0]) && (bank.wr_bank != bank.rd_bank[1]) &&
            (bank.wr_bank != bank.rd_bank[2]) && (bank.wr_bank != bank.rd_bank[3]));

endmodule

// ==== src/line_store.sv ====
// read data lags rd_col by one clock and a bank being written returns no new read data
`include "pixel_window_cfg.svh"

module line_store import pixel_pkg::*; (
    input  logic          clk,
    input  pixel_t        in_pixel,
    input  col_t          rd_col,
    output pixel_t [3:0]  row_data,
    bank_if.store         bank
);

    localparam int   ADDR_W  = $clog2(`PW_WIDTH);
    localparam col_t END_COL = col_t'(`PW_WIDTH);

    // registered read port of each bank
    pixel_t bank_q [`PW_BANKS];

    for (genvar b = 0; b < `PW_BANKS; b++) begin : g_bank
        pixel_t mem [`PW_WIDTH];
        pixel_t rd_q;
        logic   wr_sel;

        assign wr_sel = bank.wr_en && (bank.wr_bank == ctrl_pkg::bank_t'(b));

        // single port, a write takes the cycle and the read register holds
        always_ff @(posedge clk) begin
            if (wr_sel) begin
                mem[bank.wr_col[ADDR_W-1:0]] <= in_pixel;
            end else if (rd_col < END_COL) begin
                rd_q <= mem[rd_col[ADDR_W-1:0]];
            end
        end

        assign bank_q[b] = rd_q;
    end

    // route the selected bank to each window row
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            row_data[j] = bank_q[bank.rd_bank[j]];
        end
    end

    a_wr_col_range: assert property (@(posedge clk)
        bank.wr_en |-> (bank.wr_col < END_COL));

endmodule

// ==== src/window_shift.sv ====
// no column edge fill so each output row yields PW_WIDTH-3 windows
`include "pixel_window_cfg.svh"

module window_shift import pixel_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           row_active,
    input  pixel_t [3:0]   row_data,
    output col_t           rd_col,
    input  logic           out_ready,
    output logic           out_valid,
    output pixel_t [15:0]  out_window,
    output logic           row_done
);

    localparam col_t END_COL = col_t'(`PW_WIDTH);

    // next column to shift in, END_COL once the row is exhausted
    col_t       col_ptr;
    logic [2:0] load_cnt;
    logic       primed;
    logic       out_hs;
    logic       shift;

    assign out_valid = (load_cnt == 3'd4);
    assign out_hs    = out_valid && out_ready;
    assign row_done  = out_hs && (col_ptr == END_COL);

    // fill four columns first, then one new column per accepted window
    assign shift = primed && ((load_cnt < 3'd4) || (out_hs && (col_ptr != END_COL)));

    // look one column ahead on a shift so read data lines up with the next shift
    assign rd_col = shift ? col_t'(col_ptr + col_t'(1)) : col_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            primed   <= 1'b0;
            load_cnt <= '0;
            col_ptr  <= '0;
        end else if (row_done) begin
            primed   <= 1'b0;
            load_cnt <= '0;
            col_ptr  <= '0;
        end else begin
            // first active cycle only fetches column 0
            if (row_active && !primed) begin
                primed <= 1'b1;
            end
            if (shift) begin
                col_ptr <= col_ptr + col_t'(1);
                if (load_cnt < 3'd4) begin
                    load_cnt <= load_cnt + 3'd1;
                end
            end
        end
    end

    // each window row shifts left, new column enters at index 3
    always_ff @(posedge clk) begin
        if (shift) begin
            for (int i = 0; i < 4; i++) begin
                out_window[i*4]     <= out_window[i*4 + 1];
                out_window[i*4 + 1] <= out_window[i*4 + 2];
                out_window[i*4 + 2] <= out_window[i*4 + 3];
                out_window[i*4 + 3] <= row_data[i];
            end
        end
    end

    a_window_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_window)));

endmodule

// ==== src/pixel_window.sv ====
// accepts one frame per reset without column edge fill and out_window[row*4+col] is the window
module pixel_window import pixel_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    output logic           in_ready,
    input  pixel_t         in_pixel,
    output logic           out_valid,
    input  logic           out_ready,
    output pixel_t [15:0]  out_window,
    output logic           frame_done
);

    col_t          rd_col;
    pixel_t [3:0]  row_data;
    logic          row_active;
    logic          row_done;

    bank_if bank ();

    row_sequencer row_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .row_done   (row_done),
        .row_active (row_active),
        .frame_done (frame_done),
        .bank       (bank.seq)
    );

    line_store line_store_inst (
        .clk      (clk),
        .in_pixel (in_pixel),
        .rd_col   (rd_col),
        .row_data (row_data),
        .bank     (bank.store)
    );

    window_shift window_shift_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_active (row_active),
        .row_data   (row_data),
        .rd_col     (rd_col),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_window (out_window),
        .row_done   (row_done)
    );

endmodule

// ==== dv/clk_gen.sv ====
// free running clock with a 100 ns period starting low at time zero
module clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

// ==== dv/pixel_window_tb.sv ====
// the DUT takes one frame per reset so every frame test applies its own reset first
`include "pixel_window_cfg.svh"

module pixel_window_tb import pixel_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int W     = `PW_WIDTH;
    localparam int H     = `PW_HEIGHT;
    localparam int WINS  = W - 3;
    localparam int LIMIT = 40 * W * H;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic          in_ready;
    pixel_t        in_pixel;
    logic          out_valid;
    logic          out_ready;
    pixel_t [15:0] out_window;
    logic          frame_done;
    logic [31:0]   lfsr_state;

    clk_gen clk_gen_inst (
        .clk (clk)
    );

    pixel_window pixel_window_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pixel   (in_pixel),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_window (out_window),
        .frame_done (frame_done)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    // source row clamped to the frame, which is how top and bottom edges fill
    function automatic pixel_t source_pixel(input int y, input int x);
        int yc;
        yc = (y < 0) ? 0 : ((y > H - 1) ? H - 1 : y);
        return pixel_t'(yc * 256 + x + 1);
    endfunction

    task automatic check_window(input int r, input int c, input logic edges);
        for (int k = 0; k < 16; k++) begin
            compare_pixel($sformatf("out_window[%0d] row %0d col %0d", k, r, c),
                out_window[k], source_pixel(r - 1 + k / 4, c + k % 4));
        end
        for (int j = 0; j < 4; j++) begin
            if (edges && r == 0) begin
                compare_pixel("top edge out_window", out_window[j], source_pixel(0, c + j));
            end
            if (edges && r >= H - 2) begin
                compare_pixel("bottom edge out_window", out_window[12 + j],
                    source_pixel(H - 1, c + j));
            end
            if (edges && r == H - 1) begin
                compare_pixel("bottom edge out_window", out_window[8 + j],
                    source_pixel(H - 1, c + j));
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // streams one frame in and checks every window in raster order
    task automatic run_frame(input logic rand_in, input logic rand_out, input logic edges);
        int            pix_idx;
        int            win_idx;
        int            cycles;
        logic          stalled;
        logic          vld;
        pixel_t [15:0] held;
        pix_idx = 0;
        win_idx = 0;
        cycles  = 0;
        stalled = 1'b0;
        held    = '0;
        while (win_idx < H * WINS) begin
            @(posedge clk);
            vld = (pix_idx < W * H) && (rand_in ? rand_bit() : 1'b1);
            in_valid  <= vld;
            in_pixel  <= source_pixel(pix_idx / W, pix_idx % W);
            out_ready <= rand_out ? rand_bit() : 1'b1;
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                abort_run("timeout while waiting for the windows of the frame");
            end
            // the last window has not been taken yet
            compare_flag("frame_done", frame_done, 1'b0);
            if (in_valid && in_ready) begin
                pix_idx++;
            end
            if (pix_idx > (win_idx / WINS + 4) * W) begin
                abort_run("input accepted a row that would overwrite a row still in use");
            end
            if (out_valid) begin
                for (int k = 0; k < 16; k++) begin
                    if (stalled) begin
                        compare_pixel("held out_window", out_window[k], held[k]);
                    end
                end
                check_window(win_idx / WINS, win_idx % WINS, edges);
                stalled = !out_ready;
                held    = out_window;
                if (out_ready) begin
                    win_idx++;
                end
            end else if (stalled) begin
                abort_run("out_valid dropped while a window waited for out_ready");
            end
        end
    endtask

    task automatic wait_frame_done();
        int cycles;
        cycles = 0;
        while (frame_done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_run("frame_done did not rise after the last window");
            end
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        @(negedge clk);
        compare_flag("in_ready", in_ready, 1'b1);
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("frame_done", frame_done, 1'b0);
    endtask

    task automatic test_full_rate();
        apply_reset();
        run_frame(1'b0, 1'b0, 1'b1);
    endtask

    // nothing more comes out or goes in once the frame is done
    task automatic test_frame_end();
        wait_frame_done();
        repeat (10) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            out_ready <= 1'b1;
            @(negedge clk);
            compare_flag("frame_done", frame_done, 1'b1);
            compare_flag("out_valid", out_valid, 1'b0);
            compare_flag("in_ready", in_ready, 1'b0);
        end
    endtask

    task automatic test_back_pressure();
        apply_reset();
        run_frame(1'b0, 1'b1, 1'b0);
        wait_frame_done();
    endtask

    task automatic test_input_gaps();
        apply_reset();
        run_frame(1'b1, 1'b0, 1'b0);
        wait_frame_done();
    endtask

    initial begin
        lfsr_state = 32'h833a51a5;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pixel   = '0;
        out_ready  = 1'b0;
        test_reset_state();
        test_full_rate();
        test_frame_end();
        test_back_pressure();
        test_input_gaps();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== pixel_window.f ====
+incdir+src
src/pixel_pkg.sv
src/ctrl_pkg.sv
src/bank_if.sv
src/row_sequencer.sv
src/line_store.sv
src/window_shift.sv
src/pixel_window.sv
dv/clk_gen.sv
dv/pixel_window_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ns
TB_TOP    = pixel_window_tb
RTL_TOP   = pixel_window
FILELIST  = pixel_window.f
BUILD_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
